// File: hdl/tlcs_pkg.sv
/* Shared definitions for the tlcs core.
   Holds the opcodes, width codes, the instruction word layouts and
   the Wishbone request and response bundles used by every block. */
`default_nettype none

package tlcs_pkg;

    localparam int WB_ADDR_W = 16; // word address, words are 32 bits

    // codes below 6'h30 go straight to the ALU as its selector
    typedef enum logic [5:0] {
        OP_MOVE = 6'h00,
        OP_ADD  = 6'h01,
        OP_ADC  = 6'h02,
        OP_SUB  = 6'h03,
        OP_SBC  = 6'h04,
        OP_CP   = 6'h05,
        OP_AND  = 6'h06,
        OP_OR   = 6'h07,
        OP_XOR  = 6'h08,
        OP_NEG  = 6'h09,
        OP_CPL  = 6'h0a,
        OP_EXTZ = 6'h0b,
        OP_EXTS = 6'h0c,
        OP_MIRR = 6'h0d,
        OP_BS1F = 6'h0e,
        OP_BS1B = 6'h0f,
        OP_SCF  = 6'h10,
        OP_RCF  = 6'h11,
        OP_CCF  = 6'h12,
        OP_ZCF  = 6'h13,
        OP_LD   = 6'h30,
        OP_ST   = 6'h31,
        OP_HALT = 6'h3f
    } alu_op_e;

    typedef enum logic [2:0] {
        W_BYTE = 3'b001,
        W_WORD = 3'b010,
        W_LONG = 3'b100
    } width_e;

    typedef struct packed {
        alu_op_e    opcode;
        width_e     width;
        logic [2:0] dst;
        logic       imm_form; // 1 selects the immediate layout
    } instr_head_t;

    typedef struct packed {
        instr_head_t head;
        logic [2:0]  src;
        logic [15:0] unused;
    } instr_reg_t;

    typedef struct packed {
        instr_head_t head;
        logic [15:0] imm;    // zero-extended
        logic [2:0]  unused;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef struct packed {
        logic s;
        logic z;
        logic rsv5; // reads as zero
        logic h;
        logic rsv3; // reads as zero
        logic v;
        logic n;
        logic c;
    } flags_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [31:0]          dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/tlcs_alu.sv
/* Width-aware ALU with its own flag register.
   Runs one operation per go strobe; dout and flags update on that edge
   and hold otherwise. Bits of dout above the operation width are kept. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              go,
    input  tlcs_pkg::alu_op_e sel,
    input  tlcs_pkg::width_e  w,
    input  logic [31:0]       op0,     // destination operand
    input  logic [31:0]       op1,     // source operand
    input  logic [31:0]       imm,
    input  logic              sel_imm,
    output logic [31:0]       dout,
    output tlcs_pkg::flags_t  flags
);

    logic [31:0]      op2, a, b, rslt;
    logic [4:0]       s4;
    logic [8:0]       s8;
    logic [16:0]      s16;
    logic [32:0]      s32;
    logic             is_sub, cin, carry_w, ovf;
    logic [3:0]       bs_fwd, bs_bwd;
    tlcs_pkg::flags_t nx;

    function automatic logic top_bit(input logic [31:0] x, input tlcs_pkg::width_e wd);
        case (wd)
            tlcs_pkg::W_BYTE: return x[7];
            tlcs_pkg::W_WORD: return x[15];
            default:          return x[31];
        endcase
    endfunction

    function automatic logic at_zero(input logic [31:0] x, input tlcs_pkg::width_e wd);
        case (wd)
            tlcs_pkg::W_BYTE: return x[7:0] == '0;
            tlcs_pkg::W_WORD: return x[15:0] == '0;
            default:          return x == '0;
        endcase
    endfunction

    // adder and subtractor shared by ADD/ADC/SUB/SBC/CP/NEG
    always_comb begin
        op2    = sel_imm ? imm : op1;
        is_sub = sel inside {tlcs_pkg::OP_SUB, tlcs_pkg::OP_SBC, tlcs_pkg::OP_CP,
                             tlcs_pkg::OP_NEG};
        a      = (sel == tlcs_pkg::OP_NEG) ? '0 : op0; // NEG is 0 - op0
        b      = (sel == tlcs_pkg::OP_NEG) ? op0 : op2;
        cin    = (sel inside {tlcs_pkg::OP_ADC, tlcs_pkg::OP_SBC}) && flags.c;
        if (is_sub) begin
            s4  = {1'b0, a[3:0]}  - {1'b0, b[3:0]}  - {4'd0, cin};
            s8  = {1'b0, a[7:0]}  - {1'b0, b[7:0]}  - {8'd0, cin};
            s16 = {1'b0, a[15:0]} - {1'b0, b[15:0]} - {16'd0, cin};
            s32 = {1'b0, a}       - {1'b0, b}       - {32'd0, cin};
        end else begin
            s4  = {1'b0, a[3:0]}  + {1'b0, b[3:0]}  + {4'd0, cin};
            s8  = {1'b0, a[7:0]}  + {1'b0, b[7:0]}  + {8'd0, cin};
            s16 = {1'b0, a[15:0]} + {1'b0, b[15:0]} + {16'd0, cin};
            s32 = {1'b0, a}       + {1'b0, b}       + {32'd0, cin};
        end
        case (w)
            tlcs_pkg::W_BYTE: carry_w = s8[8];
            tlcs_pkg::W_WORD: carry_w = s16[16];
            default:          carry_w = s32[32];
        endcase
        // add overflows on equal signs, subtract on differing signs
        ovf = (top_bit(a, w) ^ top_bit(b, w) ^ ~is_sub)
            & (top_bit(s32[31:0], w) ^ top_bit(a, w));
    end

    // bit search over the low half of the source
    always_comb begin
        bs_fwd = '0;
        bs_bwd = '0;
        for (int i = 15; i >= 0; i--) begin
            if (op2[i]) bs_fwd = 4'(i); // lowest set bit wins
        end
        for (int i = 0; i < 16; i++) begin
            if (op2[i]) bs_bwd = 4'(i);
        end
    end

    always_comb begin
        rslt = dout;
        nx   = flags;
        case (sel)
            tlcs_pkg::OP_MOVE: rslt = op2;
            tlcs_pkg::OP_ADD, tlcs_pkg::OP_ADC, tlcs_pkg::OP_SUB,
            tlcs_pkg::OP_SBC, tlcs_pkg::OP_CP, tlcs_pkg::OP_NEG: begin
                rslt = s32[31:0];
                nx.s = top_bit(rslt, w);
                nx.z = at_zero(rslt, w);
                nx.h = s4[4];
                nx.v = ovf;
                nx.n = is_sub;
                nx.c = carry_w;
            end
            tlcs_pkg::OP_AND, tlcs_pkg::OP_OR, tlcs_pkg::OP_XOR: begin
                case (sel)
                    tlcs_pkg::OP_AND: rslt = op0 & op2;
                    tlcs_pkg::OP_OR:  rslt = op0 | op2;
                    default:          rslt = op0 ^ op2;
                endcase
                nx.s = top_bit(rslt, w);
                nx.z = at_zero(rslt, w);
                nx.h = (sel == tlcs_pkg::OP_AND);
                nx.v = (w == tlcs_pkg::W_BYTE) ? ~^rslt[7:0] : ~^rslt[15:0]; // even parity
                nx.n = 1'b0;
                nx.c = 1'b0;
            end
            tlcs_pkg::OP_CPL: begin
                rslt = ~op0;
                nx.h = 1'b1;
                nx.n = 1'b1;
            end
            tlcs_pkg::OP_EXTZ: rslt = (w == tlcs_pkg::W_WORD) ? {24'd0, op0[7:0]} : {16'd0, op0[15:0]};
            tlcs_pkg::OP_EXTS: begin
                if (w == tlcs_pkg::W_WORD) rslt = {{24{op0[7]}}, op0[7:0]};
                else rslt = {{16{op0[15]}}, op0[15:0]};
            end
            tlcs_pkg::OP_MIRR: rslt[15:0] = {<<{op0[15:0]}}; // bit reverse of low half
            tlcs_pkg::OP_BS1F: begin
                rslt = {28'd0, bs_fwd};
                nx.v = (op2[15:0] == '0);
            end
            tlcs_pkg::OP_BS1B: begin
                rslt = {28'd0, bs_bwd};
                nx.v = (op2[15:0] == '0);
            end
            tlcs_pkg::OP_SCF: begin
                nx.c = 1'b1;
                nx.h = 1'b0;
                nx.n = 1'b0;
            end
            tlcs_pkg::OP_RCF: begin
                nx.c = 1'b0;
                nx.h = 1'b0;
                nx.n = 1'b0;
            end
            tlcs_pkg::OP_CCF: begin
                nx.c = ~flags.c;
                nx.n = 1'b0;
            end
            tlcs_pkg::OP_ZCF: begin
                nx.c = ~flags.z;
                nx.n = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) flags <= '0;
        else if (go) flags <= nx;
    end

    always_ff @(posedge clk) begin
        if (go) begin
            case (w)
                tlcs_pkg::W_BYTE: dout[7:0]  <= rslt[7:0];
                tlcs_pkg::W_WORD: dout[15:0] <= rslt[15:0];
                default:          dout       <= rslt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/tlcs_regfile.sv
/* Eight 32-bit registers, two combinational read ports and one
   write port that only touches the bytes covered by the write width. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_regfile (
    input  logic             clk,
    input  logic             rst,
    input  logic [2:0]       rd_a,
    input  logic [2:0]       rd_b,
    input  logic             wr_en,
    input  logic [2:0]       wr_adr,
    input  tlcs_pkg::width_e wr_w,
    input  logic [31:0]      wr_dat,
    output logic [31:0]      rd_a_dat,
    output logic [31:0]      rd_b_dat
);

    logic [31:0] regs [8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            case (wr_w)
                tlcs_pkg::W_BYTE: regs[wr_adr][7:0]  <= wr_dat[7:0];
                tlcs_pkg::W_WORD: regs[wr_adr][15:0] <= wr_dat[15:0];
                default:          regs[wr_adr]       <= wr_dat;
            endcase
        end
    end

    assign rd_a_dat = regs[rd_a]; // no bypass
    assign rd_b_dat = regs[rd_b];

endmodule

`default_nettype wire

// File: hdl/tlcs_fetch.sv
/* Instruction fetch with a one-entry prefetch buffer.
   Reads the word at pc over Wishbone whenever the buffer is free and
   hands it to the execute unit with a valid/ready handshake. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_fetch #(
    parameter logic [tlcs_pkg::WB_ADDR_W-1:0] BOOT_ADDR = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  tlcs_pkg::wb_rsp_t fetch_rsp,
    input  logic              instr_ready,
    output tlcs_pkg::wb_req_t fetch_req,
    output tlcs_pkg::instr_t  instr,
    output logic              instr_valid
);

    logic [tlcs_pkg::WB_ADDR_W-1:0] pc;
    logic                           busy; // bus cycle in flight
    logic                           take;

    assign take = instr_valid && instr_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= BOOT_ADDR;
            busy        <= 1'b0;
            instr_valid <= 1'b0;
        end else if (busy && fetch_rsp.ack) begin
            busy        <= 1'b0; // cyc drops the cycle after ack
            instr_valid <= 1'b1;
            pc          <= pc + 1'b1;
        end else begin
            if (take) instr_valid <= 1'b0;
            // start the next read as soon as the buffer drains
            if (!busy && (!instr_valid || take)) busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && fetch_rsp.ack) instr <= fetch_rsp.dat;
    end

    always_comb begin
        fetch_req.cyc = busy;
        fetch_req.stb = busy;
        fetch_req.we  = 1'b0;
        fetch_req.adr = pc;
        fetch_req.dat = '0;
    end

endmodule

`default_nettype wire

// File: hdl/tlcs_exec.sv
/* Execute stage: decodes the instruction word, drives the ALU and
   the register file, and runs the data-side Wishbone master for LD/ST.
   ALU ops take two cycles, bus ops end on ack, HALT stops until reset. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_exec (
    input  logic              clk,
    input  logic              rst,
    input  tlcs_pkg::instr_t  instr,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  logic [31:0]       rd_a_dat,
    input  logic [31:0]       rd_b_dat,
    input  logic [31:0]       alu_dout,
    input  tlcs_pkg::wb_rsp_t data_rsp,
    output logic [2:0]        rd_a,
    output logic [2:0]        rd_b,
    output logic              alu_go,
    output tlcs_pkg::alu_op_e alu_sel,
    output tlcs_pkg::width_e  alu_w,
    output logic [31:0]       op0,
    output logic [31:0]       op1,
    output logic [31:0]       imm,
    output logic              sel_imm,
    output logic              wr_en,
    output logic [2:0]        wr_adr,
    output tlcs_pkg::width_e  wr_w,
    output logic [31:0]       wr_dat,
    output tlcs_pkg::wb_req_t data_req,
    output logic              halted
);

    localparam logic [1:0] S_READY  = 2'd0;
    localparam logic [1:0] S_ALU_WB = 2'd1;
    localparam logic [1:0] S_BUS    = 2'd2;
    localparam logic [1:0] S_HALT   = 2'd3;

    logic [1:0]                     state;
    logic                           accept, is_alu, keep_dst, wb_q, st_q;
    logic [2:0]                     dst_q;
    tlcs_pkg::width_e               w_q;
    logic [tlcs_pkg::WB_ADDR_W-1:0] adr_q;
    logic [31:0]                    dat_q;
    tlcs_pkg::instr_head_t          head;

    assign head        = instr.r.head; // same place in both layouts
    assign instr_ready = (state == S_READY);
    assign accept      = instr_valid && instr_ready;
    assign is_alu      = head.opcode < tlcs_pkg::OP_LD;
    // compare and carry ops only touch flags
    assign keep_dst    = head.opcode inside {tlcs_pkg::OP_CP, tlcs_pkg::OP_SCF,
                                             tlcs_pkg::OP_RCF, tlcs_pkg::OP_CCF,
                                             tlcs_pkg::OP_ZCF};

    assign rd_a    = head.dst;
    assign rd_b    = instr.r.src;
    assign op0     = rd_a_dat;
    assign op1     = rd_b_dat;
    assign imm     = {16'd0, instr.i.imm};
    assign sel_imm = head.imm_form;
    assign alu_sel = head.opcode;
    assign alu_w   = head.width;
    assign alu_go  = accept && is_alu;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_READY;
            wb_q  <= 1'b0;
        end else begin
            case (state)
                S_READY: if (accept) begin
                    wb_q <= !keep_dst;
                    if (is_alu) state <= S_ALU_WB;
                    else if (head.opcode inside {tlcs_pkg::OP_LD, tlcs_pkg::OP_ST}) state <= S_BUS;
                    else if (head.opcode == tlcs_pkg::OP_HALT) state <= S_HALT;
                end
                S_ALU_WB: state <= S_READY;
                S_BUS:    if (data_rsp.ack) state <= S_READY;
                default:  ; // stays halted until reset
            endcase
        end
    end

    // operands captured at accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dst_q <= head.dst;
            w_q   <= head.width;
            st_q  <= (head.opcode == tlcs_pkg::OP_ST);
            adr_q <= rd_b_dat[tlcs_pkg::WB_ADDR_W-1:0];
            dat_q <= rd_a_dat; // store data comes from dst
        end
    end

    assign wr_en  = (state == S_ALU_WB && wb_q) || (state == S_BUS && data_rsp.ack && !st_q);
    assign wr_adr = dst_q;
    assign wr_w   = (state == S_BUS) ? tlcs_pkg::W_LONG : w_q; // loads write all 32 bits
    assign wr_dat = (state == S_BUS) ? data_rsp.dat : alu_dout;

    always_comb begin
        data_req.cyc = (state == S_BUS);
        data_req.stb = (state == S_BUS);
        data_req.we  = st_q;
        data_req.adr = adr_q;
        data_req.dat = dat_q;
    end

    assign halted = (state == S_HALT);

endmodule

`default_nettype wire

// File: hdl/tlcs_wb_arbiter.sv
/* Two-master Wishbone classic arbiter.
   The owner keeps the bus until it drops cyc; an idle bus goes to the
   data master first, then to fetch. Only the owner sees ack. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_wb_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  tlcs_pkg::wb_req_t fetch_req,
    input  tlcs_pkg::wb_req_t data_req,
    input  tlcs_pkg::wb_rsp_t bus_rsp,
    output tlcs_pkg::wb_rsp_t fetch_rsp,
    output tlcs_pkg::wb_rsp_t data_rsp,
    output tlcs_pkg::wb_req_t bus_req
);

    logic own_f, own_d;
    logic held; // current owner still in its cycle

    assign held = (own_f && fetch_req.cyc) || (own_d && data_req.cyc);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            own_f <= 1'b0;
            own_d <= 1'b0;
        end else if (!held) begin
            own_d <= data_req.cyc;
            own_f <= !data_req.cyc && fetch_req.cyc;
        end
    end

    always_comb begin
        bus_req = '0;
        if (own_d) bus_req = data_req;
        else if (own_f) bus_req = fetch_req;
        fetch_rsp.ack = own_f && bus_rsp.ack;
        fetch_rsp.dat = bus_rsp.dat;
        data_rsp.ack  = own_d && bus_rsp.ack;
        data_rsp.dat  = bus_rsp.dat;
    end

endmodule

`default_nettype wire

// File: hdl/tlcs_core.sv
/* Top level of the execution subsystem.
   Connects fetch, execute, ALU and register file, and merges both
   Wishbone masters onto the external bus through the arbiter. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_core #(
    parameter logic [tlcs_pkg::WB_ADDR_W-1:0] BOOT_ADDR = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  tlcs_pkg::wb_rsp_t bus_rsp,
    output tlcs_pkg::wb_req_t bus_req,
    output tlcs_pkg::flags_t  flags,
    output logic              halted
);

    tlcs_pkg::wb_req_t fetch_req, data_req;
    tlcs_pkg::wb_rsp_t fetch_rsp, data_rsp;
    tlcs_pkg::instr_t  instr;
    tlcs_pkg::alu_op_e alu_sel;
    tlcs_pkg::width_e  alu_w, wr_w;
    logic              instr_valid, instr_ready;
    logic              alu_go, sel_imm, wr_en;
    logic [2:0]        rd_a, rd_b, wr_adr;
    logic [31:0]       rd_a_dat, rd_b_dat, alu_dout;
    logic [31:0]       op0, op1, imm, wr_dat;

    tlcs_fetch #(
        .BOOT_ADDR (BOOT_ADDR)
    ) i_fetch (
        .clk, .rst, .fetch_rsp, .instr_ready,
        .fetch_req, .instr, .instr_valid
    );

    tlcs_exec i_exec (
        .clk, .rst, .instr, .instr_valid, .instr_ready,
        .rd_a_dat, .rd_b_dat, .alu_dout, .data_rsp,
        .rd_a, .rd_b, .alu_go, .alu_sel, .alu_w, .op0, .op1, .imm, .sel_imm,
        .wr_en, .wr_adr, .wr_w, .wr_dat, .data_req, .halted
    );

    tlcs_alu i_alu (
        .clk, .rst,
        .go      (alu_go),
        .sel     (alu_sel),
        .w       (alu_w),
        .op0, .op1, .imm, .sel_imm,
        .dout    (alu_dout),
        .flags
    );

    tlcs_regfile i_regfile (
        .clk, .rst, .rd_a, .rd_b, .wr_en, .wr_adr, .wr_w, .wr_dat,
        .rd_a_dat, .rd_b_dat
    );

    tlcs_wb_arbiter i_arbiter (
        .clk, .rst, .fetch_req, .data_req, .bus_rsp,
        .fetch_rsp, .data_rsp, .bus_req
    );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
/* Free-running testbench clock, 8 ns period. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real HALF_PERIOD = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: test/tb_wb_mem.sv
/* Wishbone classic memory model of 256 words for the testbench.
   Each transfer waits 0 to 3 cycles picked by an xorshift generator,
   responses change 1 ns after the rising edge. Counts the writes. */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem (
    input  logic              clk,
    input  logic              rst,
    input  tlcs_pkg::wb_req_t req,
    output tlcs_pkg::wb_rsp_t rsp
);

    logic [31:0] mem [256];
    logic [31:0] seed;
    logic        pending;     // transfer seen, wait count drawn
    int          wait_left;
    int          store_count;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rsp         = '0;
        seed        = 32'he414;
        pending     = 1'b0;
        wait_left   = 0;
        store_count = 0;
    end

    always @(posedge clk) begin
        #1;
        if (rst) begin
            rsp         = '0;
            pending     = 1'b0;
            store_count = 0;
        end else if (rsp.ack) begin
            rsp.ack = 1'b0; // master drops cyc on this edge
            pending = 1'b0;
        end else if (req.cyc && req.stb) begin
            if (!pending) begin
                seed      = xorshift32(seed);
                wait_left = int'(seed[1:0]);
                pending   = 1'b1;
            end
            if (wait_left == 0) begin
                rsp.ack = 1'b1;
                if (req.we) begin
                    mem[req.adr[7:0]] = req.dat;
                    store_count++;
                end else begin
                    rsp.dat = mem[req.adr[7:0]];
                end
            end else begin
                wait_left--;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tlcs_core_tb.sv
/* Directed tests for the tlcs core.
   Each test builds a small program, runs it from reset until halted and
   checks stored words and flags against values worked out by hand. */
`timescale 1ns/1ps
`default_nettype none

module tlcs_core_tb;

    localparam int PROG_WORDS  = 132; // instructions over all programs
    localparam int CYCLE_LIMIT = 40 * PROG_WORDS;

    logic              clk;
    logic              rst;
    tlcs_pkg::wb_req_t bus_req;
    tlcs_pkg::wb_rsp_t bus_rsp;
    tlcs_pkg::flags_t  flags;
    logic              halted;
    logic [31:0]       prog [$];
    logic [31:0]       data_q [$];  // placed from word 0x80 up
    int                errors;
    int                cycles = 0;

    tb_clock i_clock (.clk);

    tb_wb_mem i_mem (.clk, .rst, .req(bus_req), .rsp(bus_rsp));

    tlcs_core #(
        .BOOT_ADDR (16'h0000)
    ) i_dut (
        .clk, .rst, .bus_rsp, .bus_req, .flags, .halted
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core never halted", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] fill_word(input int a);
        return 32'hdead_0000 ^ (32'(a) * 32'h0001_0101);
    endfunction

    function automatic logic [7:0] flag_byte(input logic s, z, h, v, n, c);
        return {s, z, 1'b0, h, 1'b0, v, n, c};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_stored(input logic [7:0] addr, input logic [31:0] exp);
        check_value($sformatf("mem[%02h]", addr), exp, i_mem.mem[addr]);
    endtask

    task automatic push_reg_op(input tlcs_pkg::alu_op_e op, input tlcs_pkg::width_e w,
                               input logic [2:0] dst, input logic [2:0] src);
        tlcs_pkg::instr_t ins;
        ins        = '0;
        ins.r.head = '{opcode: op, width: w, dst: dst, imm_form: 1'b0};
        ins.r.src  = src;
        prog.push_back(ins);
    endtask

    task automatic push_imm_op(input tlcs_pkg::alu_op_e op, input tlcs_pkg::width_e w,
                               input logic [2:0] dst, input logic [15:0] imm);
        tlcs_pkg::instr_t ins;
        ins        = '0;
        ins.i.head = '{opcode: op, width: w, dst: dst, imm_form: 1'b1};
        ins.i.imm  = imm;
        prog.push_back(ins);
    endtask

    task automatic move_imm(input logic [2:0] dst, input logic [15:0] imm);
        push_imm_op(tlcs_pkg::OP_MOVE, tlcs_pkg::W_LONG, dst, imm);
    endtask

    // r7 holds the store address, MOVE leaves the flags alone
    task automatic store_reg(input logic [2:0] src, input logic [7:0] addr);
        move_imm(3'd7, {8'd0, addr});
        push_reg_op(tlcs_pkg::OP_ST, tlcs_pkg::W_LONG, src, 3'd7);
    endtask

    task automatic push_halt();
        push_reg_op(tlcs_pkg::OP_HALT, tlcs_pkg::W_LONG, 3'd0, 3'd0);
    endtask

    task automatic new_program();
        prog.delete();
        data_q.delete();
    endtask

    // reset, load memory, run until halted, then check the store count
    task automatic run_program();
        tlcs_pkg::instr_t ins;
        int               stores;
        stores = 0;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int a = 0; a < 256; a++) i_mem.mem[a] = fill_word(a);
        foreach (prog[k]) begin
            ins          = prog[k];
            i_mem.mem[k] = prog[k];
            if (ins.r.head.opcode == tlcs_pkg::OP_ST) stores++;
        end
        foreach (data_q[k]) i_mem.mem[8'h80 + k] = data_q[k];
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!halted);
        check_value("store_count", stores, i_mem.store_count);
    endtask

    task automatic test_arith();
        new_program();
        data_q.push_back(32'h7fff_ffff);
        move_imm(3'd7, 16'h0080);
        push_reg_op(tlcs_pkg::OP_LD, tlcs_pkg::W_LONG, 3'd1, 3'd7);
        move_imm(3'd2, 16'h0001);
        push_reg_op(tlcs_pkg::OP_ADD, tlcs_pkg::W_LONG, 3'd1, 3'd2);
        move_imm(3'd3, 16'h00ff);
        push_imm_op(tlcs_pkg::OP_ADD, tlcs_pkg::W_BYTE, 3'd3, 16'h0001); // wraps, C set
        push_imm_op(tlcs_pkg::OP_ADC, tlcs_pkg::W_WORD, 3'd4, 16'h1234);
        move_imm(3'd5, 16'h0010);
        push_imm_op(tlcs_pkg::OP_SUB, tlcs_pkg::W_WORD, 3'd5, 16'h0020);
        push_reg_op(tlcs_pkg::OP_SBC, tlcs_pkg::W_BYTE, 3'd6, 3'd2);     // 0 - 1 - C
        push_reg_op(tlcs_pkg::OP_NEG, tlcs_pkg::W_WORD, 3'd2, 3'd0);
        store_reg(3'd1, 8'hc0);
        store_reg(3'd3, 8'hc1);
        store_reg(3'd4, 8'hc2);
        store_reg(3'd5, 8'hc3);
        store_reg(3'd6, 8'hc4);
        store_reg(3'd2, 8'hc5);
        push_halt();
        run_program();
        check_stored(8'hc0, 32'h7fff_ffff + 32'd1);
        check_stored(8'hc1, 32'h0000_0000);
        check_stored(8'hc2, 32'h1234 + 32'd1);  // carry from the byte add
        check_stored(8'hc3, 32'h0000_fff0);
        check_stored(8'hc4, 32'h0000_00fe);
        check_stored(8'hc5, 32'h0000_ffff);
        // 0 - 1 at word width borrows out of bit 3 and the top
        check_value("flags", flag_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1), flags);
    endtask

    task automatic test_logic();
        new_program();
        move_imm(3'd1, 16'h00f0);
        move_imm(3'd2, 16'h0f3c);
        push_reg_op(tlcs_pkg::OP_AND, tlcs_pkg::W_WORD, 3'd1, 3'd2);
        move_imm(3'd3, 16'h1234);
        push_imm_op(tlcs_pkg::OP_OR, tlcs_pkg::W_WORD, 3'd3, 16'h8001);
        move_imm(3'd4, 16'h00aa);
        push_reg_op(tlcs_pkg::OP_SCF, tlcs_pkg::W_LONG, 3'd0, 3'd0); // XOR has to clear it
        push_imm_op(tlcs_pkg::OP_XOR, tlcs_pkg::W_BYTE, 3'd4, 16'h00ff);
        move_imm(3'd5, 16'h5a0f);
        push_reg_op(tlcs_pkg::OP_CPL, tlcs_pkg::W_BYTE, 3'd5, 3'd0);
        store_reg(3'd1, 8'hc0);
        store_reg(3'd3, 8'hc1);
        store_reg(3'd4, 8'hc2);
        store_reg(3'd5, 8'hc3);
        push_halt();
        run_program();
        check_stored(8'hc0, 32'h00f0 & 32'h0f3c);
        check_stored(8'hc1, 32'h1234 | 32'h8001);
        check_stored(8'hc2, 32'h00aa ^ 32'h00ff);
        check_stored(8'hc3, 32'h0000_5af0);
        // V is parity from XOR, H and N come from CPL
        check_value("flags", flag_byte(1'b0, 1'b0, 1'b1, ~^8'h55, 1'b1, 1'b0), flags);

        new_program();
        move_imm(3'd1, 16'h0080);
        push_imm_op(tlcs_pkg::OP_CP, tlcs_pkg::W_BYTE, 3'd1, 16'h0001);
        store_reg(3'd1, 8'hc0);
        push_halt();
        run_program();
        check_stored(8'hc0, 32'h0000_0080);  // CP leaves r1 as it was
        check_value("flags", flag_byte(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0), flags);
    endtask

    task automatic test_bit_ops();
        new_program();
        move_imm(3'd1, 16'h9c80);
        push_reg_op(tlcs_pkg::OP_MOVE, tlcs_pkg::W_LONG, 3'd2, 3'd1);
        push_reg_op(tlcs_pkg::OP_EXTZ, tlcs_pkg::W_WORD, 3'd2, 3'd0);
        push_reg_op(tlcs_pkg::OP_MOVE, tlcs_pkg::W_LONG, 3'd3, 3'd1);
        push_reg_op(tlcs_pkg::OP_EXTS, tlcs_pkg::W_LONG, 3'd3, 3'd0);
        push_reg_op(tlcs_pkg::OP_MOVE, tlcs_pkg::W_LONG, 3'd4, 3'd1);
        push_reg_op(tlcs_pkg::OP_MIRR, tlcs_pkg::W_WORD, 3'd4, 3'd0);
        push_reg_op(tlcs_pkg::OP_BS1F, tlcs_pkg::W_BYTE, 3'd5, 3'd1);
        push_reg_op(tlcs_pkg::OP_BS1B, tlcs_pkg::W_BYTE, 3'd6, 3'd1);
        push_reg_op(tlcs_pkg::OP_BS1F, tlcs_pkg::W_BYTE, 3'd0, 3'd0); // r0 still zero
        store_reg(3'd2, 8'hc0);
        store_reg(3'd3, 8'hc1);
        store_reg(3'd4, 8'hc2);
        store_reg(3'd5, 8'hc3);
        store_reg(3'd6, 8'hc4);
        push_halt();
        run_program();
        check_stored(8'hc0, 32'h0000_0080);
        check_stored(8'hc1, 32'hffff_9c80);
        check_stored(8'hc2, 32'h0000_0139);  // 1001_1100_1000_0000 reversed
        check_stored(8'hc3, 32'd7);
        check_stored(8'hc4, 32'd15);
        check_value("flags", flag_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0), flags);

        // flags start from reset, so only BS1B can set V here
        new_program();
        push_reg_op(tlcs_pkg::OP_BS1B, tlcs_pkg::W_BYTE, 3'd0, 3'd0);
        push_halt();
        run_program();
        check_value("flags", flag_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0), flags);
    endtask

    task automatic test_partial_writes();
        new_program();
        data_q.push_back(32'h89ab_cdef);
        move_imm(3'd7, 16'h0080);
        push_reg_op(tlcs_pkg::OP_LD, tlcs_pkg::W_LONG, 3'd1, 3'd7);
        push_imm_op(tlcs_pkg::OP_MOVE, tlcs_pkg::W_BYTE, 3'd1, 16'h0012);
        push_reg_op(tlcs_pkg::OP_LD, tlcs_pkg::W_LONG, 3'd2, 3'd7);
        push_imm_op(tlcs_pkg::OP_MOVE, tlcs_pkg::W_WORD, 3'd2, 16'h3456);
        push_reg_op(tlcs_pkg::OP_LD, tlcs_pkg::W_LONG, 3'd3, 3'd7);
        push_imm_op(tlcs_pkg::OP_ADD, tlcs_pkg::W_WORD, 3'd3, 16'h0001);
        store_reg(3'd1, 8'hc0);
        store_reg(3'd2, 8'hc1);
        store_reg(3'd3, 8'hc2);
        push_halt();
        run_program();
        check_stored(8'hc0, 32'h89ab_cd12);
        check_stored(8'hc1, 32'h89ab_3456);
        check_stored(8'hc2, 32'h89ab_cdf0);
        check_value("flags", flag_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0), flags);
    endtask

    // one run per step, the flags model follows the carry rules
    task automatic test_carry_ops();
        tlcs_pkg::alu_op_e seq [4];
        tlcs_pkg::flags_t  f;
        seq = '{tlcs_pkg::OP_SCF, tlcs_pkg::OP_CCF, tlcs_pkg::OP_ZCF, tlcs_pkg::OP_RCF};
        for (int k = 1; k <= 4; k++) begin
            new_program();
            move_imm(3'd1, 16'h0001);
            push_imm_op(tlcs_pkg::OP_SUB, tlcs_pkg::W_LONG, 3'd1, 16'h0002);
            f = flag_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1); // 1 - 2
            for (int j = 0; j < k; j++) begin
                push_reg_op(seq[j], tlcs_pkg::W_LONG, 3'd0, 3'd0);
                case (seq[j])
                    tlcs_pkg::OP_SCF: begin
                        f.c = 1'b1;
                        f.h = 1'b0;
                        f.n = 1'b0;
                    end
                    tlcs_pkg::OP_RCF: begin
                        f.c = 1'b0;
                        f.h = 1'b0;
                        f.n = 1'b0;
                    end
                    tlcs_pkg::OP_CCF: begin
                        f.c = ~f.c;
                        f.n = 1'b0;
                    end
                    default: begin
                        f.c = ~f.z; // ZCF
                        f.n = 1'b0;
                    end
                endcase
            end
            push_halt();
            run_program();
            check_value($sformatf("flags step %0d", k), f, flags);
        end
    endtask

    task automatic test_bus_sharing();
        logic [31:0] image [256];
        new_program();
        for (int k = 0; k < 6; k++) begin
            data_q.push_back(32'h5a00_0000 + 32'(k) * 32'h0011_0101);
            move_imm(3'd6, 16'h0080 + 16'(k));
            move_imm(3'd7, 16'h00c0 + 16'(k));
            push_reg_op(tlcs_pkg::OP_LD, tlcs_pkg::W_LONG, 3'd1, 3'd6);
            push_reg_op(tlcs_pkg::OP_ST, tlcs_pkg::W_LONG, 3'd1, 3'd7);
        end
        push_halt();
        run_program();
        for (int a = 0; a < 256; a++) image[a] = fill_word(a);
        foreach (prog[k]) image[k] = prog[k];
        foreach (data_q[k]) begin
            image[8'h80 + k] = data_q[k];
            image[8'hc0 + k] = data_q[k]; // copied by the LD/ST pair
        end
        for (int a = 0; a < 256; a++) begin
            check_value($sformatf("mem[%02h]", a), image[a], i_mem.mem[a]);
        end
        check_value("flags", 32'h0000_0000, flags);
    endtask

    initial begin
        errors = 0;
        rst    = 1'b1;
        test_arith();
        test_logic();
        test_bit_ops();
        test_partial_writes();
        test_carry_ops();
        test_bus_sharing();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tlcs_core.f
hdl/tlcs_pkg.sv
hdl/tlcs_alu.sv
hdl/tlcs_regfile.sv
hdl/tlcs_fetch.sv
hdl/tlcs_exec.sv
hdl/tlcs_wb_arbiter.sv
hdl/tlcs_core.sv
test/tb_clock.sv
test/tb_wb_mem.sv
test/tlcs_core_tb.sv
